//--- hw/controlPkg.sv
`include "control_defs.svh"

package controlPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLui   = 6'h0F,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcode_t;

    typedef enum logic [`FUNCT_W-1:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnSlt = 6'h2A
    } funct_t;

    typedef enum logic [3:0] {
        clsRtype,
        clsAddi,
        clsLui,
        clsLoad,
        clsStore,
        clsBeq,
        clsBne,
        clsJump,
        clsJal,
        clsIllegal
    } instrClass_t;

    // One state per phase, all 16 codes in use
    typedef enum logic [3:0] {
        stFetch,
        stDecode,
        stRtypeExec,
        stAddiExec,
        stLuiExec,
        stAluWbRd,
        stAluWbRt,
        stMemAddr,
        stLoadAccess,
        stLoadCapture,
        stLoadWb,
        stStore,
        stBeq,
        stBne,
        stJump,
        stJal
    } ctrlState_t;

endpackage

//--- hw/controlSignalGen.sv
`include "control_defs.svh"

module controlSignalGen (
    input  controlPkg::ctrlState_t state,
    input  logic                   active,
    output logic                   pcWrite,
    output logic                   pcWriteCondBeq,
    output logic                   pcWriteCondBne,
    output logic                   irWrite,
    output logic                   memWrite,
    output logic                   iorD,
    output logic                   mdrWrite,
    output logic                   loadA,
    output logic                   loadB,
    output logic                   aluOutWrite,
    output logic                   regWrite,
    output logic [`SEL2_W-1:0]     aluOp,
    output logic                   aluSrcA,
    output logic [`ALUSRCB_W-1:0]  aluSrcB,
    output logic [`SEL2_W-1:0]     pcSource,
    output logic [`SEL2_W-1:0]     regDst,
    output logic [`SEL2_W-1:0]     memToReg
);
    import controlPkg::*;

    always_comb begin
        pcWrite        = 1'b0;
        pcWriteCondBeq = 1'b0;
        pcWriteCondBne = 1'b0;
        irWrite        = 1'b0;
        memWrite       = 1'b0;
        iorD           = 1'b0;
        mdrWrite       = 1'b0;
        loadA          = 1'b0;
        loadB          = 1'b0;
        aluOutWrite    = 1'b0;
        regWrite       = 1'b0;
        aluOp          = `ALUOP_ADD;
        aluSrcA        = `ALUSRCA_PC;
        aluSrcB        = `ALUSRCB_REGB;
        pcSource       = `PCSRC_ALURESULT;
        regDst         = `REGDST_RT;
        memToReg       = `MEMTOREG_ALUOUT;

        // Idle until the sequencer has left reset
        if (active) begin
            case (state)
                stFetch: begin
                    pcWrite = 1'b1;
                    irWrite = 1'b1;
                    aluSrcA = `ALUSRCA_PC;
                    aluSrcB = `ALUSRCB_FOUR;
                    aluOp   = `ALUOP_ADD;
                end
                stDecode: begin
                    // Branch target computed ahead of the branch state
                    loadA       = 1'b1;
                    loadB       = 1'b1;
                    aluOutWrite = 1'b1;
                    aluSrcB     = `ALUSRCB_BROFFSET;
                end
                stRtypeExec: begin
                    aluSrcA     = `ALUSRCA_REGA;
                    aluSrcB     = `ALUSRCB_REGB;
                    aluOp       = `ALUOP_FUNCT;
                    aluOutWrite = 1'b1;
                end
                stAddiExec, stMemAddr: begin
                    aluSrcA     = `ALUSRCA_REGA;
                    aluSrcB     = `ALUSRCB_SIGNIMM;
                    aluOutWrite = 1'b1;
                end
                stLuiExec: begin
                    aluSrcB     = `ALUSRCB_UPPERIMM;
                    aluOutWrite = 1'b1;
                end
                stAluWbRd: begin
                    regWrite = 1'b1;
                    regDst   = `REGDST_RD;
                    memToReg = `MEMTOREG_ALUOUT;
                end
                stAluWbRt: begin
                    regWrite = 1'b1;
                    regDst   = `REGDST_RT;
                    memToReg = `MEMTOREG_ALUOUT;
                end
                stLoadAccess: begin
                    iorD = 1'b1;
                end
                stLoadCapture: begin
                    iorD     = 1'b1;
                    mdrWrite = 1'b1;
                end
                stLoadWb: begin
                    regWrite = 1'b1;
                    regDst   = `REGDST_RT;
                    memToReg = `MEMTOREG_MDR;
                end
                stStore: begin
                    iorD     = 1'b1;
                    memWrite = 1'b1;
                end
                stBeq, stBne: begin
                    aluSrcA        = `ALUSRCA_REGA;
                    aluSrcB        = `ALUSRCB_REGB;
                    aluOp          = `ALUOP_SUB;
                    pcSource       = `PCSRC_ALUOUT;
                    pcWriteCondBeq = (state == stBeq);
                    pcWriteCondBne = (state == stBne);
                end
                stJump: begin
                    pcWrite  = 1'b1;
                    pcSource = `PCSRC_JUMP;
                end
                stJal: begin
                    pcWrite  = 1'b1;
                    pcSource = `PCSRC_JUMP;
                    regWrite = 1'b1;
                    regDst   = `REGDST_RA;
                    memToReg = `MEMTOREG_PC;
                end
                default: begin
                    pcWrite = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- hw/controlUnit.sv
`include "control_defs.svh"

module controlUnit (
    input  logic                  clk,
    input  logic                  resett,
    input  controlPkg::opcode_t   opcode,
    input  controlPkg::funct_t    funct,
    output logic                  illegal,
    output logic                  pcWrite,
    output logic                  pcWriteCondBeq,
    output logic                  pcWriteCondBne,
    output logic                  irWrite,
    output logic                  memWrite,
    output logic                  iorD,
    output logic                  mdrWrite,
    output logic                  loadA,
    output logic                  loadB,
    output logic                  aluOutWrite,
    output logic                  regWrite,
    output logic [`SEL2_W-1:0]    aluOp,
    output logic                  aluSrcA,
    output logic [`ALUSRCB_W-1:0] aluSrcB,
    output logic [`SEL2_W-1:0]    pcSource,
    output logic [`SEL2_W-1:0]    regDst,
    output logic [`SEL2_W-1:0]    memToReg
);
    import controlPkg::*;

    instrClass_t instrClass;
    ctrlState_t  state;
    logic        active;

    instrDecoder i_instrDecoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    mainSequencer i_mainSequencer (
        .clk        (clk),
        .resett     (resett),
        .instrClass (instrClass),
        .state      (state),
        .active     (active),
        .illegal    (illegal)
    );

    controlSignalGen i_controlSignalGen (
        .state          (state),
        .active         (active),
        .pcWrite        (pcWrite),
        .pcWriteCondBeq (pcWriteCondBeq),
        .pcWriteCondBne (pcWriteCondBne),
        .irWrite        (irWrite),
        .memWrite       (memWrite),
        .iorD           (iorD),
        .mdrWrite       (mdrWrite),
        .loadA          (loadA),
        .loadB          (loadB),
        .aluOutWrite    (aluOutWrite),
        .regWrite       (regWrite),
        .aluOp          (aluOp),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .pcSource       (pcSource),
        .regDst         (regDst),
        .memToReg       (memToReg)
    );

endmodule

//--- hw/control_defs.svh
`ifndef CONTROL_DEFS_SVH
`define CONTROL_DEFS_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// Select widths
`define ALUSRCB_W 3
`define SEL2_W 2

// Cycles the memory needs before load data can be captured
`define MEM_WAIT_CYCLES 3

// ALU A operand
`define ALUSRCA_PC 1'b0
`define ALUSRCA_REGA 1'b1

// ALU B operand
`define ALUSRCB_REGB 3'd0
`define ALUSRCB_FOUR 3'd1
`define ALUSRCB_SIGNIMM 3'd2
`define ALUSRCB_UPPERIMM 3'd3
`define ALUSRCB_BROFFSET 3'd4

// ALU operation; FUNCT lets the datapath decode funct itself
`define ALUOP_ADD 2'd0
`define ALUOP_SUB 2'd1
`define ALUOP_FUNCT 2'd2

// Next PC source
`define PCSRC_ALURESULT 2'd0
`define PCSRC_ALUOUT 2'd1
`define PCSRC_JUMP 2'd2

// Destination register
`define REGDST_RT 2'd0
`define REGDST_RD 2'd1
`define REGDST_RA 2'd2

// Register write data
`define MEMTOREG_ALUOUT 2'd0
`define MEMTOREG_MDR 2'd1
`define MEMTOREG_PC 2'd2

`endif

//--- hw/instrDecoder.sv
module instrDecoder (
    input  controlPkg::opcode_t     opcode,
    input  controlPkg::funct_t      funct,
    output controlPkg::instrClass_t instrClass
);
    import controlPkg::*;

    logic rtypeKnown;

    // ALU decodes funct on its own, so all four share one class
    always_comb begin
        case (funct)
            fnAdd, fnSub, fnAnd, fnSlt: begin
                rtypeKnown = 1'b1;
            end
            default: begin
                rtypeKnown = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            opRtype: begin
                instrClass = rtypeKnown ? clsRtype : clsIllegal;
            end
            opAddi: begin
                instrClass = clsAddi;
            end
            opLui: begin
                instrClass = clsLui;
            end
            opLw: begin
                instrClass = clsLoad;
            end
            opSw: begin
                instrClass = clsStore;
            end
            opBeq: begin
                instrClass = clsBeq;
            end
            opBne: begin
                instrClass = clsBne;
            end
            opJ: begin
                instrClass = clsJump;
            end
            opJal: begin
                instrClass = clsJal;
            end
            default: begin
                instrClass = clsIllegal;
            end
        endcase
    end

endmodule

//--- hw/mainSequencer.sv
`include "control_defs.svh"

module mainSequencer (
    input  logic                    clk,
    input  logic                    resett,
    input  controlPkg::instrClass_t instrClass,
    output controlPkg::ctrlState_t  state,
    output logic                    active,
    output logic                    illegal
);
    import controlPkg::*;

    // Counter runs 0 .. MEM_WAIT_CYCLES-1 while the memory answers
    localparam int WAIT_W = (`MEM_WAIT_CYCLES > 1) ? $clog2(`MEM_WAIT_CYCLES) : 1;
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`MEM_WAIT_CYCLES - 1);

    ctrlState_t        nextState;
    logic [WAIT_W-1:0] waitCount;

    // First edge after reset only arms the unit; fetch starts there
    always_ff @(posedge clk) begin
        if (resett) begin
            state     <= stFetch;
            active    <= 1'b0;
            waitCount <= '0;
        end else begin
            active <= 1'b1;
            if (active) begin
                state <= nextState;
            end
            if (state == stLoadAccess) begin
                waitCount <= waitCount + 1'b1;
            end else begin
                waitCount <= '0;
            end
        end
    end

    always_comb begin
        nextState = stFetch;
        case (state)
            stFetch: begin
                nextState = stDecode;
            end
            stDecode: begin
                case (instrClass)
                    clsRtype:         nextState = stRtypeExec;
                    clsAddi:          nextState = stAddiExec;
                    clsLui:           nextState = stLuiExec;
                    clsLoad, clsStore: nextState = stMemAddr;
                    clsBeq:           nextState = stBeq;
                    clsBne:           nextState = stBne;
                    clsJump:          nextState = stJump;
                    clsJal:           nextState = stJal;
                    // Unknown instruction goes straight back to fetch
                    default:          nextState = stFetch;
                endcase
            end
            stRtypeExec: begin
                nextState = stAluWbRd;
            end
            stAddiExec, stLuiExec: begin
                nextState = stAluWbRt;
            end
            stMemAddr: begin
                nextState = (instrClass == clsLoad) ? stLoadAccess : stStore;
            end
            stLoadAccess: begin
                nextState = (waitCount == WAIT_LAST) ? stLoadCapture : stLoadAccess;
            end
            stLoadCapture: begin
                nextState = stLoadWb;
            end
            default: begin
                nextState = stFetch;
            end
        endcase
    end

    assign illegal = (state == stDecode) && (instrClass == clsIllegal);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module controlUnitTb \
    -o controlUnitTb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/controlUnitTb_sim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- sim/controlUnitTb.sv
`include "control_defs.svh"

module controlUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import controlPkg::*;

    localparam int RANDOM_INSTRS = 40;
    localparam int DIRECTED_INSTRS = 14;
    localparam int LONGEST_INSTR = 5 + `MEM_WAIT_CYCLES;
    // Every instruction at the longest length plus reset and slack
    localparam int LIMIT_NS = ((RANDOM_INSTRS + DIRECTED_INSTRS) * LONGEST_INSTR + 20) * 10;
    localparam logic [31:0] SEED = 32'h8afe56ba;

    // One phase per expected control word
    typedef enum int {
        phIdle, phFetch, phDecode, phDecodeIllegal, phRtypeExec, phAddiExec, phLuiExec,
        phAluWbRd, phAluWbRt, phMemAddr, phLoadAccess, phLoadCapture, phLoadWb,
        phStore, phBeq, phBne, phJump, phJal
    } phase_t;

    typedef struct packed {
        logic                  illegal;
        logic                  pcWrite;
        logic                  pcWriteCondBeq;
        logic                  pcWriteCondBne;
        logic                  irWrite;
        logic                  memWrite;
        logic                  iorD;
        logic                  mdrWrite;
        logic                  loadA;
        logic                  loadB;
        logic                  aluOutWrite;
        logic                  regWrite;
        logic [`SEL2_W-1:0]    aluOp;
        logic                  aluSrcA;
        logic [`ALUSRCB_W-1:0] aluSrcB;
        logic [`SEL2_W-1:0]    pcSource;
        logic [`SEL2_W-1:0]    regDst;
        logic [`SEL2_W-1:0]    memToReg;
    } ctrlWord_t;

    logic                  clk;
    logic                  resett;
    opcode_t               opcode;
    funct_t                funct;
    logic                  illegal;
    logic                  pcWrite;
    logic                  pcWriteCondBeq;
    logic                  pcWriteCondBne;
    logic                  irWrite;
    logic                  memWrite;
    logic                  iorD;
    logic                  mdrWrite;
    logic                  loadA;
    logic                  loadB;
    logic                  aluOutWrite;
    logic                  regWrite;
    logic [`SEL2_W-1:0]    aluOp;
    logic                  aluSrcA;
    logic [`ALUSRCB_W-1:0] aluSrcB;
    logic [`SEL2_W-1:0]    pcSource;
    logic [`SEL2_W-1:0]    regDst;
    logic [`SEL2_W-1:0]    memToReg;

    int     errorCount;
    phase_t expSeq[$];

    controlUnit i_controlUnit (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected outputs per phase
    function automatic ctrlWord_t wordFor(phase_t ph);
        ctrlWord_t w;
        w = '0;
        case (ph)
            phFetch: begin
                w.pcWrite = 1'b1;
                w.irWrite = 1'b1;
                w.aluSrcA = `ALUSRCA_PC;
                w.aluSrcB = `ALUSRCB_FOUR;
                w.aluOp   = `ALUOP_ADD;
            end
            phDecode, phDecodeIllegal: begin
                w.illegal     = (ph == phDecodeIllegal);
                w.loadA       = 1'b1;
                w.loadB       = 1'b1;
                w.aluOutWrite = 1'b1;
                w.aluSrcB     = `ALUSRCB_BROFFSET;
            end
            phRtypeExec: begin
                w.aluSrcA     = `ALUSRCA_REGA;
                w.aluSrcB     = `ALUSRCB_REGB;
                w.aluOp       = `ALUOP_FUNCT;
                w.aluOutWrite = 1'b1;
            end
            phAddiExec, phMemAddr: begin
                w.aluSrcA     = `ALUSRCA_REGA;
                w.aluSrcB     = `ALUSRCB_SIGNIMM;
                w.aluOutWrite = 1'b1;
            end
            phLuiExec: begin
                w.aluSrcB     = `ALUSRCB_UPPERIMM;
                w.aluOutWrite = 1'b1;
            end
            phAluWbRd, phAluWbRt, phLoadWb: begin
                w.regWrite = 1'b1;
                w.regDst   = (ph == phAluWbRd) ? `REGDST_RD : `REGDST_RT;
                w.memToReg = (ph == phLoadWb) ? `MEMTOREG_MDR : `MEMTOREG_ALUOUT;
            end
            phLoadAccess: begin
                w.iorD = 1'b1;
            end
            phLoadCapture: begin
                w.iorD     = 1'b1;
                w.mdrWrite = 1'b1;
            end
            phStore: begin
                w.iorD     = 1'b1;
                w.memWrite = 1'b1;
            end
            phBeq, phBne: begin
                w.aluSrcA        = `ALUSRCA_REGA;
                w.aluSrcB        = `ALUSRCB_REGB;
                w.aluOp          = `ALUOP_SUB;
                w.pcSource       = `PCSRC_ALUOUT;
                w.pcWriteCondBeq = (ph == phBeq);
                w.pcWriteCondBne = (ph == phBne);
            end
            phJump, phJal: begin
                w.pcWrite  = 1'b1;
                w.pcSource = `PCSRC_JUMP;
                w.regWrite = (ph == phJal);
                w.regDst   = (ph == phJal) ? `REGDST_RA : `REGDST_RT;
                w.memToReg = (ph == phJal) ? `MEMTOREG_PC : `MEMTOREG_ALUOUT;
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    task automatic checkValue(string what, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic compareWord(phase_t ph);
        ctrlWord_t exp;
        string     tag;
        exp = wordFor(ph);
        tag = ph.name();
        checkValue({tag, " illegal"}, 32'(illegal), 32'(exp.illegal));
        checkValue({tag, " pcWrite"}, 32'(pcWrite), 32'(exp.pcWrite));
        checkValue({tag, " pcWriteCondBeq"}, 32'(pcWriteCondBeq), 32'(exp.pcWriteCondBeq));
        checkValue({tag, " pcWriteCondBne"}, 32'(pcWriteCondBne), 32'(exp.pcWriteCondBne));
        checkValue({tag, " irWrite"}, 32'(irWrite), 32'(exp.irWrite));
        checkValue({tag, " memWrite"}, 32'(memWrite), 32'(exp.memWrite));
        checkValue({tag, " iorD"}, 32'(iorD), 32'(exp.iorD));
        checkValue({tag, " mdrWrite"}, 32'(mdrWrite), 32'(exp.mdrWrite));
        checkValue({tag, " loadA"}, 32'(loadA), 32'(exp.loadA));
        checkValue({tag, " loadB"}, 32'(loadB), 32'(exp.loadB));
        checkValue({tag, " aluOutWrite"}, 32'(aluOutWrite), 32'(exp.aluOutWrite));
        checkValue({tag, " regWrite"}, 32'(regWrite), 32'(exp.regWrite));
        checkValue({tag, " aluOp"}, 32'(aluOp), 32'(exp.aluOp));
        checkValue({tag, " aluSrcA"}, 32'(aluSrcA), 32'(exp.aluSrcA));
        checkValue({tag, " aluSrcB"}, 32'(aluSrcB), 32'(exp.aluSrcB));
        checkValue({tag, " pcSource"}, 32'(pcSource), 32'(exp.pcSource));
        checkValue({tag, " regDst"}, 32'(regDst), 32'(exp.regDst));
        checkValue({tag, " memToReg"}, 32'(memToReg), 32'(exp.memToReg));
    endtask

    // Phases from one fetch to the cycle before the next
    task automatic planSequence(opcode_t op, funct_t fn);
        int k;
        expSeq = '{phFetch};
        case (op)
            opRtype: begin
                if (fn inside {fnAdd, fnSub, fnAnd, fnSlt}) begin
                    expSeq = {expSeq, phDecode, phRtypeExec, phAluWbRd};
                end else begin
                    expSeq.push_back(phDecodeIllegal);
                end
            end
            opAddi: expSeq = {expSeq, phDecode, phAddiExec, phAluWbRt};
            opLui:  expSeq = {expSeq, phDecode, phLuiExec, phAluWbRt};
            opLw: begin
                expSeq = {expSeq, phDecode, phMemAddr};
                for (k = 0; k < `MEM_WAIT_CYCLES; k++) begin
                    expSeq.push_back(phLoadAccess);
                end
                expSeq = {expSeq, phLoadCapture, phLoadWb};
            end
            opSw:   expSeq = {expSeq, phDecode, phMemAddr, phStore};
            opBeq:  expSeq = {expSeq, phDecode, phBeq};
            opBne:  expSeq = {expSeq, phDecode, phBne};
            opJ:    expSeq = {expSeq, phDecode, phJump};
            opJal:  expSeq = {expSeq, phDecode, phJal};
            default: expSeq.push_back(phDecodeIllegal);
        endcase
    endtask

    // Enters and leaves on the falling edge of a fetch cycle
    task automatic runInstr(opcode_t op, funct_t fn);
        int i;
        planSequence(op, fn);
        opcode = op;
        funct  = fn;
        for (i = 0; i < expSeq.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            compareWord(expSeq[i]);
        end
        @(negedge clk);
    endtask

    task automatic resetAndRelease();
        resett = 1'b1;
        repeat (2) begin
            @(negedge clk);
            compareWord(phIdle);
        end
        resett = 1'b0;
        @(negedge clk);
    endtask

    task automatic aluInstrSequences();
        runInstr(opRtype, fnAdd);
        runInstr(opRtype, fnSub);
        runInstr(opRtype, fnAnd);
        runInstr(opRtype, fnSlt);
        runInstr(opAddi, fnAdd);
        runInstr(opLui, fnAdd);
    endtask

    task automatic memoryAccesses();
        runInstr(opLw, fnAdd);
        runInstr(opSw, fnAdd);
    endtask

    task automatic branchesAndJumps();
        runInstr(opBeq, fnAdd);
        runInstr(opBne, fnAdd);
        runInstr(opJ, fnAdd);
        runInstr(opJal, fnAdd);
    endtask

    task automatic illegalDecodes();
        runInstr(opcode_t'(6'h3F), fnAdd);
        runInstr(opRtype, funct_t'(6'h1A));
    endtask

    task automatic randomInstrStream();
        opcode_t opPool[$] = '{opRtype, opAddi, opLui, opLw, opSw, opBeq, opBne, opJ, opJal};
        funct_t  fnPool[$] = '{fnAdd, fnSub, fnAnd, fnSlt};
        opcode_t op;
        funct_t  fn;
        int      n;
        for (n = 0; n < RANDOM_INSTRS; n++) begin
            op = opPool[$urandom_range(opPool.size() - 1)];
            fn = fnPool[$urandom_range(fnPool.size() - 1)];
            runInstr(op, fn);
        end
        // Last instruction must hand over to a fresh fetch
        compareWord(phFetch);
    endtask

    initial begin
        resett     = 1'b1;
        opcode     = opRtype;
        funct      = fnAdd;
        errorCount = 0;
        void'($urandom(SEED));
        resetAndRelease();
        aluInstrSequences();
        memoryAccesses();
        branchesAndJumps();
        illegalDecodes();
        randomInstrStream();
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS * 1ns);
        $display("Errors found");
        $fatal(1, "Timeout: the tests did not finish within %0d ns", LIMIT_NS);
    end

endmodule

//--- sim/controlUnit_props.sv
module controlUnitProps (
    input logic clk,
    input logic resett,
    input logic pcWrite,
    input logic pcWriteCondBeq,
    input logic pcWriteCondBne,
    input logic memWrite,
    input logic iorD,
    input logic irWrite,
    input logic illegal
);
    timeunit 1ns;
    timeprecision 1ps;

    // Unconditional and conditional PC writes are exclusive
    pcWriteExclusive: assert property (@(posedge clk) disable iff (resett)
        !(pcWrite && (pcWriteCondBeq || pcWriteCondBne)))
        else $error("pcWrite raised together with a conditional PC write");

    storeUsesDataAddr: assert property (@(posedge clk) disable iff (resett)
        memWrite |-> iorD)
        else $error("memWrite without iorD");

    fetchAdvancesPc: assert property (@(posedge clk) disable iff (resett)
        irWrite |-> pcWrite)
        else $error("irWrite without pcWrite");

    // Illegal decode goes straight back to fetch
    illegalRefetches: assert property (@(posedge clk) disable iff (resett)
        illegal |=> irWrite)
        else $error("No fetch after an illegal instruction");

endmodule

bind controlUnit controlUnitProps i_controlUnitProps (
    .clk            (clk),
    .resett         (resett),
    .pcWrite        (pcWrite),
    .pcWriteCondBeq (pcWriteCondBeq),
    .pcWriteCondBne (pcWriteCondBne),
    .memWrite       (memWrite),
    .iorD           (iorD),
    .irWrite        (irWrite),
    .illegal        (illegal)
);

//--- tb.f
+incdir+hw
hw/controlPkg.sv
hw/instrDecoder.sv
hw/mainSequencer.sv
hw/controlSignalGen.sv
hw/controlUnit.sv
sim/controlUnit_props.sv
sim/controlUnitTb.sv
